// File: files.f
common/p4_egress_pkg.sv
verilog/egr_port_demux.sv
egr_buffer/egr_pkt_buffer.sv
egr_width_conv/egr_width_conv.sv
verilog/egr_frame_counters.sv
verilog/p4_router_egress.sv
tb/p4_router_egress_tb.sv

// File: tb/p4_router_egress_tb.sv
// Egress stage testbench
// Random packets checked by assertions against a byte-level reference model
`timescale 1ns/1ps
`default_nettype none

module p4_router_egress_tb import p4_egress_pkg::*;;

    localparam int NP = 6;

    logic                core_clk_ifc;
    logic                reset;
    logic                in_valid;
    egr_word_u           in_data;
    egr_keep_t           in_keep;
    logic                in_last;
    egr_port_t           in_port;
    logic [NP-1:0]       port_enable;
    logic [NP-1:0]       cnt_clear;
    logic [2:0]          p8_valid;
    logic [2:0][7:0]     p8_data;
    logic [2:0]          p8_last;
    logic [2:0]          p8_ready;
    logic [2:0]          p32_valid;
    logic [2:0][31:0]    p32_data;
    logic [2:0][3:0]     p32_keep;
    logic [2:0]          p32_last;
    logic [2:0]          p32_ready;
    logic [NP-1:0]       buf_full_drop;
    logic [NP-1:0][31:0] frame_cnt;

    // Reference model of expected bytes and packet lengths per port
    logic [7:0] exp_mem [NP][8192];
    int         plen [NP][1024];
    int         head [NP];
    int         tail [NP];
    int         pk_head [NP];
    int         pk_tail [NP];
    int         pos [NP];
    int         delivered [NP];
    int         drop_cnt [NP];

    int            mismatch_errs = 0;
    int            other_errs = 0;
    bit            rand_ready;
    bit            drop_allowed;
    logic [NP-1:0] stall_mask;

    p4_router_egress #(
        .NUM_8B_PORTS    (3),
        .NUM_32B_PORTS   (3),
        .BUF_DEPTH_WORDS (64)
    ) DUT (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        mismatch_errs++;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        other_errs++;
    endtask

    //////////////////////////////////////////////////
    // Output checking

    task automatic check_beat(input int p, input logic [31:0] data, input logic [3:0] keep,
                              input logic last, input int width);
        int         remain;
        int         n;
        logic [3:0] exp_keep;
        has_pkt: assert (pk_head[p] != pk_tail[p]) else begin
            report_error($sformatf("port %0d delivered a beat with no packet expected", p));
            return;
        end
        remain   = plen[p][pk_head[p]] - pos[p];
        n        = (remain < width) ? remain : width;
        exp_keep = 4'((1 << n) - 1);
        if (width == 4) begin
            keep_ok: assert (keep == exp_keep) else
                report_mismatch($sformatf("port %0d keep %h, expected %h", p, keep, exp_keep));
        end
        for (int b = 0; b < n; b++) begin
            data_ok: assert (data[8*b +: 8] == exp_mem[p][head[p]]) else
                report_mismatch($sformatf("port %0d byte %0d is %h, expected %h", p,
                                          pos[p] + b, data[8*b +: 8], exp_mem[p][head[p]]));
            head[p]++;
        end
        pos[p] += n;
        last_ok: assert (last == (pos[p] == plen[p][pk_head[p]])) else
            report_mismatch($sformatf("port %0d last is %b at byte %0d", p, last, pos[p]));
        if (pos[p] == plen[p][pk_head[p]]) begin
            pk_head[p]++;
            pos[p] = 0;
            delivered[p]++;
        end
    endtask

    // A drop pulse marks the packet being written to the port
    task automatic drop_packet(input int p);
        drop_cnt[p]++;
        had_pkt: assert (pk_tail[p] > pk_head[p]) else begin
            report_error($sformatf("drop pulse on port %0d with no packet pending", p));
            return;
        end
        pk_tail[p]--;
        tail[p] -= plen[p][pk_tail[p]];
    endtask

    always @(negedge core_clk_ifc) begin
        if (!reset) begin
            for (int i = 0; i < 3; i++) begin
                if (p8_valid[i] && p8_ready[i]) begin
                    check_beat(i, {24'h0, p8_data[i]}, 4'b0001, p8_last[i], 1);
                end
                if (p32_valid[i] && p32_ready[i]) begin
                    check_beat(3 + i, p32_data[i], p32_keep[i], p32_last[i], 4);
                end
            end
            for (int p = 0; p < NP; p++) begin
                if (buf_full_drop[p]) begin
                    drop_packet(p);
                end
            end
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_stable
        hold8: assert property (@(posedge core_clk_ifc) disable iff (reset)
            p8_valid[i] && !p8_ready[i] |=>
                p8_valid[i] && $stable(p8_data[i]) && $stable(p8_last[i]))
            else report_mismatch($sformatf("8-bit port %0d beat changed before accept", i));
        hold32: assert property (@(posedge core_clk_ifc) disable iff (reset)
            p32_valid[i] && !p32_ready[i] |=> p32_valid[i] && $stable(p32_data[i]) &&
                $stable(p32_keep[i]) && $stable(p32_last[i]))
            else report_mismatch($sformatf("32-bit port %0d beat changed before accept", i));
    end

    no_drop: assert property (@(posedge core_clk_ifc) disable iff (reset)
        !drop_allowed |-> buf_full_drop == '0)
        else report_mismatch("buf_full_drop pulsed with no overflow expected");

    quiet_port: assert property (@(posedge core_clk_ifc) disable iff (reset)
        ({p32_valid, p8_valid} & ~port_enable) == '0)
        else report_mismatch("valid raised on a disabled port");

    //////////////////////////////////////////////////
    // Stimulus

    task automatic drive_ready();
        logic [NP-1:0] next_ready;
        forever begin
            @(posedge core_clk_ifc);
            next_ready = (rand_ready ? NP'($urandom) : '1) & ~stall_mask;
            #1;
            {p32_ready, p8_ready} = next_ready;
        end
    endtask

    task automatic send_pkt(input int port, input int len);
        logic [7:0] pkt [200];
        bit         keep_it;
        int         nwords;
        keep_it = port_enable[port];
        nwords  = (len + 7) / 8;
        for (int b = 0; b < len; b++) begin
            pkt[b] = 8'($urandom);
        end
        if (keep_it) begin
            plen[port][pk_tail[port]] = len;
            pk_tail[port]++;
            for (int b = 0; b < len; b++) begin
                exp_mem[port][tail[port]] = pkt[b];
                tail[port]++;
            end
        end
        for (int w = 0; w < nwords; w++) begin
            in_valid = 1'b1;
            in_port  = egr_port_t'(port);
            in_last  = (w == nwords - 1);
            for (int b = 0; b < 8; b++) begin
                in_keep[b]       = (w * 8 + b < len);
                in_data.bytes[b] = (w * 8 + b < len) ? pkt[w * 8 + b] : 8'h00;
            end
            @(posedge core_clk_ifc);
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_keep  = '0;
        // Idle gap so a drop pulse lands before the next packet is queued
        repeat (3) begin
            @(posedge core_clk_ifc);
            #1;
        end
    endtask

    function automatic bit all_drained();
        for (int p = 0; p < NP; p++) begin
            if (pk_head[p] != pk_tail[p]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        while (!all_drained() && cycles < max_cycles) begin
            @(posedge core_clk_ifc);
            #1;
            cycles++;
        end
        if (!all_drained()) begin
            report_error($sformatf("packets still pending after %0d cycles", max_cycles));
        end
    endtask

    task automatic send_round();
        for (int p = 0; p < NP; p++) begin
            send_pkt(p, 8 + int'($urandom % 193));
        end
        wait_drain(5000);
    endtask

    task automatic overflow_test(input int p);
        int base_del;
        int base_drop;
        base_del     = delivered[p];
        base_drop    = drop_cnt[p];
        drop_allowed = 1'b1;
        stall_mask[p] = 1'b1;
        @(posedge core_clk_ifc);
        #1;
        repeat (5) send_pkt(p, 200);
        drop_seen: assert (drop_cnt[p] > base_drop) else
            report_error($sformatf("no drop pulse on stalled port %0d", p));
        stall_mask[p] = 1'b0;
        wait_drain(5000);
        drop_allowed = 1'b0;
        sum_ok: assert (delivered[p] - base_del + drop_cnt[p] - base_drop == 5) else
            report_mismatch($sformatf("port %0d delivered %0d and dropped %0d of 5", p,
                                      delivered[p] - base_del, drop_cnt[p] - base_drop));
        repeat (2) send_pkt(p, 200);
        wait_drain(5000);
    endtask

    task automatic check_counters();
        @(posedge core_clk_ifc);
        #1;
        for (int p = 0; p < NP; p++) begin
            cnt_ok: assert (frame_cnt[p] == 32'(delivered[p])) else
                report_mismatch($sformatf("frame_cnt[%0d] is %0d, expected %0d", p,
                                          frame_cnt[p], delivered[p]));
        end
        cnt_clear[2] = 1'b1;
        @(posedge core_clk_ifc);
        #1;
        cnt_clear = '0;
        for (int p = 0; p < NP; p++) begin
            clr_ok: assert (frame_cnt[p] == ((p == 2) ? 32'd0 : 32'(delivered[p]))) else
                report_mismatch($sformatf("frame_cnt[%0d] is %0d after clearing port 2", p,
                                          frame_cnt[p]));
        end
    endtask

    initial begin
        void'($urandom(37144));
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '0;
        in_last      = 1'b0;
        in_port      = '0;
        port_enable  = '1;
        cnt_clear    = '0;
        p8_ready     = '1;
        p32_ready    = '1;
        rand_ready   = 1'b0;
        drop_allowed = 1'b0;
        stall_mask   = '0;
        for (int p = 0; p < NP; p++) begin
            head[p] = 0;
            tail[p] = 0;
            pk_head[p] = 0;
            pk_tail[p] = 0;
            pos[p] = 0;
            delivered[p] = 0;
            drop_cnt[p] = 0;
        end
        fork
            drive_ready();
        join_none
        repeat (8) @(posedge core_clk_ifc);
        #1;
        reset = 1'b0;

        // Routing with every port ready
        repeat (4) send_round();

        // One port off and then all ports off
        port_enable = 6'b111101;
        repeat (2) send_round();
        port_enable = '0;
        send_round();
        repeat (20) @(posedge core_clk_ifc);
        #1;
        port_enable = '1;

        overflow_test(4);

        rand_ready = 1'b1;
        repeat (6) send_round();
        rand_ready = 1'b0;

        check_counters();

        $display("Errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/p4_router_egress.sv
// Packet router egress stage
// Demux, per-port packet buffers, width converters and frame counters
`timescale 1ns/1ps
`default_nettype none

module p4_router_egress import p4_egress_pkg::*; #(
    parameter int NUM_8B_PORTS    = 3,
    parameter int NUM_32B_PORTS   = 3,
    parameter int BUF_DEPTH_WORDS = 64,
    localparam int NUM_PORTS      = NUM_8B_PORTS + NUM_32B_PORTS
) (
    input  wire logic                                      core_clk_ifc,
    input  wire logic                                      reset,

    input  wire logic                                      in_valid,
    input  wire egr_word_u                                 in_data,
    input  wire egr_keep_t                                 in_keep,
    input  wire logic                                      in_last,
    input  wire egr_port_t                                 in_port,

    input  wire logic [NUM_PORTS-1:0]                      port_enable,
    input  wire logic [NUM_PORTS-1:0]                      cnt_clear,

    output logic [NUM_8B_PORTS-1:0]                        p8_valid,
    output logic [NUM_8B_PORTS-1:0][7:0]                   p8_data,
    output logic [NUM_8B_PORTS-1:0]                        p8_last,
    input  wire logic [NUM_8B_PORTS-1:0]                   p8_ready,

    output logic [NUM_32B_PORTS-1:0]                       p32_valid,
    output logic [NUM_32B_PORTS-1:0][31:0]                 p32_data,
    output logic [NUM_32B_PORTS-1:0][3:0]                  p32_keep,
    output logic [NUM_32B_PORTS-1:0]                       p32_last,
    input  wire logic [NUM_32B_PORTS-1:0]                  p32_ready,

    output logic [NUM_PORTS-1:0]                           buf_full_drop,
    output logic [NUM_PORTS-1:0][FRAME_CNT_WIDTH-1:0]      frame_cnt
);

    logic [NUM_PORTS-1:0] wr_en;
    egr_word_u            wr_data;
    egr_keep_t            wr_keep;
    logic                 wr_last;

    logic [NUM_PORTS-1:0]            rd_valid;
    egr_word_u [NUM_PORTS-1:0]       rd_data;
    egr_keep_t [NUM_PORTS-1:0]       rd_keep;
    logic [NUM_PORTS-1:0]            rd_last;
    logic [NUM_PORTS-1:0]            rd_ready;
    logic [NUM_PORTS-1:0]            frame_done;

    egr_port_demux #(
        .NUM_PORTS (NUM_PORTS)
    ) port_demux (
        .clk         (core_clk_ifc),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_keep     (in_keep),
        .in_last     (in_last),
        .in_port     (in_port),
        .port_enable (port_enable),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .wr_keep     (wr_keep),
        .wr_last     (wr_last)
    );

    //////////////////////////////////////////////////
    // Store-and-forward buffer per port

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_buf
        egr_pkt_buffer #(
            .BUF_DEPTH_WORDS (BUF_DEPTH_WORDS)
        ) pkt_buffer (
            .clk           (core_clk_ifc),
            .reset         (reset),
            .wr_en         (wr_en[p]),
            .wr_data       (wr_data),
            .wr_keep       (wr_keep),
            .wr_last       (wr_last),
            .rd_ready      (rd_ready[p]),
            .rd_valid      (rd_valid[p]),
            .rd_data       (rd_data[p]),
            .rd_keep       (rd_keep[p]),
            .rd_last       (rd_last[p]),
            .buf_full_drop (buf_full_drop[p])
        );
    end

    //////////////////////////////////////////////////
    // Width converters, 8-bit ports first

    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_conv8
        egr_width_conv #(
            .OUT_BYTES (1)
        ) width_conv (
            .clk        (core_clk_ifc),
            .reset      (reset),
            .rd_valid   (rd_valid[i]),
            .rd_data    (rd_data[i]),
            .rd_keep    (rd_keep[i]),
            .rd_last    (rd_last[i]),
            .rd_ready   (rd_ready[i]),
            .out_ready  (p8_ready[i]),
            .out_valid  (p8_valid[i]),
            .out_data   (p8_data[i]),
            .out_keep   (),
            .out_last   (p8_last[i]),
            .frame_done (frame_done[i])
        );
    end

    for (genvar i = 0; i < NUM_32B_PORTS; i++) begin : g_conv32
        egr_width_conv #(
            .OUT_BYTES (4)
        ) width_conv (
            .clk        (core_clk_ifc),
            .reset      (reset),
            .rd_valid   (rd_valid[NUM_8B_PORTS+i]),
            .rd_data    (rd_data[NUM_8B_PORTS+i]),
            .rd_keep    (rd_keep[NUM_8B_PORTS+i]),
            .rd_last    (rd_last[NUM_8B_PORTS+i]),
            .rd_ready   (rd_ready[NUM_8B_PORTS+i]),
            .out_ready  (p32_ready[i]),
            .out_valid  (p32_valid[i]),
            .out_data   (p32_data[i]),
            .out_keep   (p32_keep[i]),
            .out_last   (p32_last[i]),
            .frame_done (frame_done[NUM_8B_PORTS+i])
        );
    end

    egr_frame_counters #(
        .NUM_PORTS (NUM_PORTS)
    ) frame_counters (
        .clk        (core_clk_ifc),
        .reset      (reset),
        .frame_done (frame_done),
        .cnt_clear  (cnt_clear),
        .frame_cnt  (frame_cnt)
    );

endmodule

`default_nettype wire

// File: verilog/egr_frame_counters.sv
// Egress frame counters
// One wrapping delivered-frame count per port with its own clear
`timescale 1ns/1ps
`default_nettype none

module egr_frame_counters import p4_egress_pkg::*; #(
    parameter int NUM_PORTS = 6
) (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire logic [NUM_PORTS-1:0]                 frame_done,
    input  wire logic [NUM_PORTS-1:0]                 cnt_clear,
    output logic [NUM_PORTS-1:0][FRAME_CNT_WIDTH-1:0] frame_cnt
);

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_cnt <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Clear has priority over a frame in the same cycle
                if (cnt_clear[p]) begin
                    frame_cnt[p] <= '0;
                end else if (frame_done[p]) begin
                    frame_cnt[p] <= frame_cnt[p] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: egr_width_conv/egr_width_conv.sv
// Egress width converter
// Splits each 64-bit buffered word into 8-bit or 32-bit beats
`timescale 1ns/1ps
`default_nettype none

module egr_width_conv import p4_egress_pkg::*; #(
    // 1 for byte ports, 4 for lane ports
    parameter int OUT_BYTES = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              rd_valid,
    input  wire egr_word_u         rd_data,
    input  wire egr_keep_t         rd_keep,
    input  wire logic              rd_last,
    input  wire logic              out_ready,
    output logic                   rd_ready,
    output logic                   out_valid,
    output logic [OUT_BYTES*8-1:0] out_data,
    output logic [OUT_BYTES-1:0]   out_keep,
    output logic                   out_last,
    output logic                   frame_done
);

    localparam int BEATS = EGR_BUS_BYTES / OUT_BYTES;
    localparam int IDX_W = $clog2(BEATS);

    egr_word_u        hold_data;
    egr_keep_t        hold_keep;
    logic             hold_last;
    logic             word_valid;
    logic [IDX_W-1:0] beat_idx;
    logic [IDX_W-1:0] next_idx;
    logic [BEATS-1:0] beat_kept;
    logic             beat_final;
    logic             beat_xfer;

    always_comb begin
        for (int b = 0; b < BEATS; b++) begin
            beat_kept[b] = |hold_keep[b*OUT_BYTES +: OUT_BYTES];
        end
    end

    // Keep is contiguous from byte 0, so empty beats only trail the word
    assign next_idx   = beat_idx + 1'b1;
    assign beat_final = (beat_idx == IDX_W'(BEATS - 1)) || !beat_kept[next_idx];
    assign beat_xfer  = out_valid && out_ready;

    // A new word only once the held one has gone out
    assign rd_ready   = !word_valid;

    assign out_valid  = word_valid;
    assign out_keep   = hold_keep[beat_idx*OUT_BYTES +: OUT_BYTES];
    assign out_last   = hold_last && beat_final;
    assign frame_done = beat_xfer && out_last;

    if (OUT_BYTES == 1) begin : g_byte_view
        assign out_data = hold_data.bytes[beat_idx];
    end else begin : g_lane_view
        assign out_data = hold_data.lanes[beat_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid <= 1'b0;
            beat_idx   <= '0;
        end else if (!word_valid) begin
            if (rd_valid) begin
                word_valid <= 1'b1;
                beat_idx   <= '0;
            end
        end else if (out_ready) begin
            if (beat_final) begin
                word_valid <= 1'b0;
            end else begin
                beat_idx <= next_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            hold_data <= rd_data;
            hold_keep <= rd_keep;
            hold_last <= rd_last;
        end
    end

endmodule

`default_nettype wire

// File: egr_buffer/egr_pkt_buffer.sv
// Egress packet buffer
// Store-and-forward FIFO, a packet that overflows is dropped whole
`timescale 1ns/1ps
`default_nettype none

module egr_pkt_buffer import p4_egress_pkg::*; #(
    // Power of two
    parameter int BUF_DEPTH_WORDS = 64
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      wr_en,
    input  wire egr_word_u wr_data,
    input  wire egr_keep_t wr_keep,
    input  wire logic      wr_last,
    input  wire logic      rd_ready,
    output logic           rd_valid,
    output egr_word_u      rd_data,
    output egr_keep_t      rd_keep,
    output logic           rd_last,
    output logic           buf_full_drop
);

    localparam int ADDR_W = $clog2(BUF_DEPTH_WORDS);

    egr_word_u mem_data [BUF_DEPTH_WORDS];
    egr_keep_t mem_keep [BUF_DEPTH_WORDS];
    logic      mem_last [BUF_DEPTH_WORDS];

    // One extra bit on each pointer tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] commit_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic dropping;
    logic buf_full;
    logic wr_accept;
    logic rd_load;

    assign buf_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign wr_accept = wr_en && !dropping && !buf_full;

    // Only committed words are visible to the read side
    assign rd_load   = (commit_ptr != rd_ptr) && (!rd_valid || rd_ready);

    //////////////////////////////////////////////////
    // Write side

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= wr_data;
            mem_keep[wr_ptr[ADDR_W-1:0]] <= wr_keep;
            mem_last[wr_ptr[ADDR_W-1:0]] <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            commit_ptr    <= '0;
            dropping      <= 1'b0;
            buf_full_drop <= 1'b0;
        end else begin
            buf_full_drop <= 1'b0;
            if (wr_en) begin
                if (dropping) begin
                    // Discard the rest of the packet
                    if (wr_last) begin
                        dropping <= 1'b0;
                    end
                end else if (buf_full) begin
                    // Rewind over the partial packet, one pulse per packet
                    wr_ptr        <= commit_ptr;
                    dropping      <= !wr_last;
                    buf_full_drop <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side, registered output word

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else if (rd_load) begin
            rd_ptr   <= rd_ptr + 1'b1;
            rd_valid <= 1'b1;
        end else if (rd_ready) begin
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_load) begin
            rd_data <= mem_data[rd_ptr[ADDR_W-1:0]];
            rd_keep <= mem_keep[rd_ptr[ADDR_W-1:0]];
            rd_last <= mem_last[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/egr_port_demux.sv
// Egress port demux
// Registers the input bus and steers each packet to one port buffer
`timescale 1ns/1ps
`default_nettype none

module egr_port_demux import p4_egress_pkg::*; #(
    parameter int NUM_PORTS = 6
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 in_valid,
    input  wire egr_word_u            in_data,
    input  wire egr_keep_t            in_keep,
    input  wire logic                 in_last,
    input  wire egr_port_t            in_port,
    input  wire logic [NUM_PORTS-1:0] port_enable,
    output logic [NUM_PORTS-1:0]      wr_en,
    output egr_word_u                 wr_data,
    output egr_keep_t                 wr_keep,
    output logic                      wr_last
);

    logic                     in_sop;
    egr_port_t                pkt_port;
    logic                     pkt_en;
    egr_port_t                cur_port;
    logic                     cur_en;
    logic [MAX_EGR_PORTS-1:0] enable_ext;

    // Port numbers beyond NUM_PORTS see a zero enable
    assign enable_ext = MAX_EGR_PORTS'(port_enable);

    // First word picks port and enable, later words reuse the latched pair
    assign cur_port = in_sop ? in_port : pkt_port;
    assign cur_en   = in_sop ? enable_ext[in_port] : pkt_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_sop   <= 1'b1;
            pkt_port <= '0;
            pkt_en   <= 1'b0;
            wr_en    <= '0;
        end else begin
            if (in_valid) begin
                in_sop   <= in_last;
                pkt_port <= cur_port;
                pkt_en   <= cur_en;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_en[p] <= in_valid && cur_en && (cur_port == egr_port_t'(p));
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= in_data;
        wr_keep <= in_keep;
        wr_last <= in_last;
    end

endmodule

`default_nettype wire

// File: common/p4_egress_pkg.sv
// Egress stage shared definitions
// Bus widths, port limits and the 64-bit data word views
`default_nettype none

package p4_egress_pkg;

    // Input bus geometry
    localparam int EGR_BUS_BYTES = 8;
    localparam int EGR_BUS_WIDTH = EGR_BUS_BYTES * 8;

    // Limit on the total port count, sizes the port number field
    localparam int MAX_EGR_PORTS = 16;

    localparam int FRAME_CNT_WIDTH = 32;

    typedef logic [$clog2(MAX_EGR_PORTS)-1:0] egr_port_t;
    typedef logic [EGR_BUS_BYTES-1:0]         egr_keep_t;

    // One bus word seen as bytes or as 32-bit lanes
    // Index 0 is the lowest bits and the first on the wire
    typedef union packed {
        logic [EGR_BUS_BYTES-1:0][7:0]    bytes;
        logic [EGR_BUS_WIDTH/32-1:0][31:0] lanes;
    } egr_word_u;

endpackage

`default_nettype wire
